/* logic/pool_consts.svh */
/*
 * Average pooling engine constants
 * Image and pool geometry, output resolution and the widths derived from them
 */
`ifndef POOL_CONSTS_SVH
`define POOL_CONSTS_SVH

// Input image side in pixels
`define POOL_IMG_SIDE 16

// Pool side is a power of two so that n*n divides by shifting
`define POOL_N 4

// Bits per output pixel
`define POOL_OUT_RES 8

`define POOL_OUT_SIDE (`POOL_IMG_SIDE / `POOL_N)
`define POOL_COUNT (`POOL_OUT_SIDE * `POOL_OUT_SIDE)
`define POOL_IDX_W ((`POOL_COUNT > 1) ? $clog2(`POOL_COUNT) : 1)
`define POOL_AREA (`POOL_N * `POOL_N)

// Needs to hold the full count of an all-ones pool
`define POOL_ONES_W $clog2(`POOL_AREA + 1)

`endif

/* logic/pool_pkg.sv */
/*
 * Average pooling package
 * Vector types for images, pools and pixels, and the sequencer states
 */
`default_nettype none

`include "pool_consts.svh"

package pool_pkg;

    // Flat input image with pixel (r,c) at bit r*side+c
    typedef logic [`POOL_IMG_SIDE*`POOL_IMG_SIDE-1:0] image_t;

    // Pixels of one pool in row-major order
    typedef logic [`POOL_AREA-1:0] pool_bits_t;

    // Pool number counted row-major over the output image
    typedef logic [`POOL_IDX_W-1:0] pool_idx_t;

    typedef logic [`POOL_ONES_W-1:0] ones_t;

    typedef logic [`POOL_OUT_RES-1:0] avg_pixel_t;

    // Flat output image with pixel k at bits k*res upward
    typedef logic [`POOL_COUNT*`POOL_OUT_RES-1:0] out_image_t;

    typedef enum logic [1:0] {
        seq_idle,
        seq_average,
        seq_drain
    } seq_state_t;

endpackage

`default_nettype wire

/* logic/avg_result_if.sv */
/*
 * Averaged pixel link
 * One pooled result with its index and end-of-frame mark
 */
`timescale 1ns/1ps
`default_nettype none

interface avg_result_if;

    logic                   valid;
    pool_pkg::pool_idx_t    index;
    pool_pkg::avg_pixel_t   value;
    // Set on the final pool of a frame
    logic                   last;

    modport producer (
        output valid,
        output index,
        output value,
        output last
    );

    modport consumer (
        input valid,
        input index,
        input value,
        input last
    );

endinterface

`default_nettype wire

/* logic/pool_sequencer_fsm.sv */
/*
 * Pool sequencer
 * Starts a frame, steps through all pools and waits for the last write
 */
`timescale 1ns/1ps
`default_nettype none

module pool_sequencer_fsm (
    input  logic clk,
    input  logic reset,
    input  logic en,
    input  logic start,
    input  logic last_pool,
    input  logic done,
    output logic count_en,
    output logic count_clear,
    output logic issue
);

    pool_pkg::seq_state_t state;
    pool_pkg::seq_state_t state_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= pool_pkg::seq_idle;
        end else if (en) begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            pool_pkg::seq_idle: begin
                if (start) begin
                    state_next = pool_pkg::seq_average;
                end
            end
            pool_pkg::seq_average: begin
                if (last_pool) begin
                    state_next = pool_pkg::seq_drain;
                end
            end
            pool_pkg::seq_drain: begin
                // Hold off a new start until the buffer has written the frame
                if (done) begin
                    state_next = pool_pkg::seq_idle;
                end
            end
            default: state_next = pool_pkg::seq_idle;
        endcase
    end

    assign count_en    = (state == pool_pkg::seq_average);
    assign issue       = (state == pool_pkg::seq_average);
    assign count_clear = (state == pool_pkg::seq_idle);

endmodule

`default_nettype wire

/* logic/pool_counter.sv */
/*
 * Pool index counter
 * Counts pools of a frame and flags the last one
 */
`timescale 1ns/1ps
`default_nettype none

`include "pool_consts.svh"

module pool_counter (
    input  logic                clk,
    input  logic                reset,
    input  logic                en,
    input  logic                count_en,
    input  logic                count_clear,
    output pool_pkg::pool_idx_t index,
    output logic                last_pool
);

    localparam pool_pkg::pool_idx_t LAST_INDEX = pool_pkg::pool_idx_t'(`POOL_COUNT - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            index <= '0;
        end else if (en) begin
            if (count_clear) begin
                index <= '0;
            end else if (count_en) begin
                // Wraps so the counter is back at zero after a frame
                index <= last_pool ? '0 : index + 1'b1;
            end
        end
    end

    assign last_pool = (index == LAST_INDEX);

endmodule

`default_nettype wire

/* logic/pool_gather.sv */
/*
 * Pool gather
 * Picks the n x n pixels of the indexed pool out of the flat image
 */
`timescale 1ns/1ps
`default_nettype none

`include "pool_consts.svh"

module pool_gather (
    input  pool_pkg::image_t     image,
    input  pool_pkg::pool_idx_t  index,
    output pool_pkg::pool_bits_t pool_bits
);

    int pool_row;
    int pool_col;

    // Output row and column of the pool
    assign pool_row = int'(index) / `POOL_OUT_SIDE;
    assign pool_col = int'(index) % `POOL_OUT_SIDE;

    always_comb begin
        int img_row;
        int img_col;
        pool_bits = '0;
        for (int k = 0; k < `POOL_N; k++) begin
            for (int l = 0; l < `POOL_N; l++) begin
                img_row = pool_row * `POOL_N + k;
                img_col = pool_col * `POOL_N + l;
                pool_bits[k*`POOL_N + l] = image[img_row*`POOL_IMG_SIDE + img_col];
            end
        end
    end

endmodule

`default_nettype wire

/* logic/pixel_averager.sv */
/*
 * Pixel averager
 * Counts set pixels of one pool, scales the count to the output
 * resolution with saturation, and registers it with its index
 */
`timescale 1ns/1ps
`default_nettype none

`include "pool_consts.svh"

module pixel_averager (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 en,
    input  logic                 issue,
    input  pool_pkg::pool_idx_t  index,
    input  pool_pkg::pool_bits_t pool_bits,
    input  logic                 last_pool,
    avg_result_if.producer       res
);

    localparam int AREA_LOG2 = $clog2(`POOL_AREA);
    localparam int SCALED_W  = `POOL_ONES_W + `POOL_OUT_RES;

    pool_pkg::ones_t       ones;
    logic [SCALED_W-1:0]   scaled;
    pool_pkg::avg_pixel_t  value_next;

    // Population count
    always_comb begin
        ones = '0;
        for (int i = 0; i < `POOL_AREA; i++) begin
            ones = ones + pool_pkg::ones_t'(pool_bits[i]);
        end
    end

    // Scaled count is ones * 2^res / n^2
    // An all-ones pool lands one past the top code and saturates
    assign scaled = {ones, {`POOL_OUT_RES{1'b0}}} >> AREA_LOG2;

    assign value_next = (scaled > SCALED_W'({`POOL_OUT_RES{1'b1}})) ?
                        '1 : scaled[`POOL_OUT_RES-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            res.valid <= 1'b0;
        end else if (en) begin
            res.valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            res.value <= value_next;
            res.index <= index;
            res.last  <= last_pool;
        end
    end

endmodule

`default_nettype wire

/* logic/output_buffer.sv */
/*
 * Output buffer
 * Writes averaged pixels into the flat output image and flags frame end
 */
`timescale 1ns/1ps
`default_nettype none

`include "pool_consts.svh"

module output_buffer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 en,
    avg_result_if.consumer       res,
    output pool_pkg::out_image_t output_pixels,
    output logic                 done
);

    logic done_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            output_pixels <= '0;
        end else if (en && res.valid) begin
            // Other slots keep the previous frame until overwritten
            output_pixels[int'(res.index)*`POOL_OUT_RES +: `POOL_OUT_RES] <= res.value;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            done_q <= 1'b0;
        end else if (en) begin
            done_q <= res.valid && res.last;
        end
    end

    // Pulse shows on the next enabled cycle only
    assign done = done_q && en;

endmodule

`default_nettype wire

/* logic/average_pooling_top.sv */
/*
 * Average pooling engine
 * Binary image in, one pooled pixel per enabled clock, done at frame end
 */
`timescale 1ns/1ps
`default_nettype none

module average_pooling_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 en,
    input  logic                 start,
    input  pool_pkg::image_t     input_pixels,
    output pool_pkg::out_image_t output_pixels,
    output logic                 done
);

    logic                 count_en;
    logic                 count_clear;
    logic                 issue;
    logic                 last_pool;
    pool_pkg::pool_idx_t  index;
    pool_pkg::pool_bits_t pool_bits;

    avg_result_if res_if ();

    pool_sequencer_fsm i_pool_sequencer_fsm (
        .clk         (clk),
        .reset       (reset),
        .en          (en),
        .start       (start),
        .last_pool   (last_pool),
        .done        (done),
        .count_en    (count_en),
        .count_clear (count_clear),
        .issue       (issue)
    );

    pool_counter i_pool_counter (
        .clk         (clk),
        .reset       (reset),
        .en          (en),
        .count_en    (count_en),
        .count_clear (count_clear),
        .index       (index),
        .last_pool   (last_pool)
    );

    // input_pixels has to stay put from start until done
    pool_gather i_pool_gather (
        .image     (input_pixels),
        .index     (index),
        .pool_bits (pool_bits)
    );

    pixel_averager i_pixel_averager (
        .clk       (clk),
        .reset     (reset),
        .en        (en),
        .issue     (issue),
        .index     (index),
        .pool_bits (pool_bits),
        .last_pool (last_pool),
        .res       (res_if.producer)
    );

    output_buffer i_output_buffer (
        .clk           (clk),
        .reset         (reset),
        .en            (en),
        .res           (res_if.consumer),
        .output_pixels (output_pixels),
        .done          (done)
    );

endmodule

`default_nettype wire

/* tb/clock_gen.sv */
/*
 * Testbench clock and reset
 * 10 ns clock, reset held high for the first 4 cycles
 */
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
    output logic clk,
    output logic reset
);

    localparam int HALF_PERIOD_NS = 5;
    localparam int RESET_CYCLES   = 4;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD_NS clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

/* tb/average_pooling_tb.sv */
/*
 * Average pooling testbench
 * Runs a table of frames with reference model, latency and done checks
 */
`timescale 1ns/1ps
`default_nettype none

`include "pool_consts.svh"

module average_pooling_tb;

    localparam int CLK_PERIOD_NS = 10;
    localparam int NUM_FRAMES    = 9;
    localparam int MAX_GAP       = 3;
    localparam int QUIET_LONG    = `POOL_COUNT + 4;
    localparam int WATCHDOG_CYCLES =
        20 + NUM_FRAMES * (`POOL_COUNT + 2 + QUIET_LONG) * (MAX_GAP + 1);

    localparam int KIND_ZERO    = 0;
    localparam int KIND_ONES    = 1;
    localparam int KIND_CHECKER = 2;
    localparam int KIND_POOL    = 3;
    localparam int KIND_RANDOM  = 4;

    typedef struct packed {
        int kind;
        int gap;       // Disabled cycles after each enabled one
        int stray_at;  // Frame cycle of an extra start or 0 for none
        int quiet;     // Idle cycles after done
        int pool_sel;
    } frame_t;

    logic                 clk;
    logic                 reset;
    logic                 en;
    logic                 start;
    logic                 done;
    pool_pkg::image_t     input_pixels;
    pool_pkg::out_image_t output_pixels;
    int                   seed;
    frame_t               frames [NUM_FRAMES];

    clock_gen i_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    average_pooling_top i_average_pooling_top (
        .clk           (clk),
        .reset         (reset),
        .en            (en),
        .start         (start),
        .input_pixels  (input_pixels),
        .output_pixels (output_pixels),
        .done          (done)
    );

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_pixel(input int index, input pool_pkg::avg_pixel_t got,
                               input pool_pkg::avg_pixel_t exp);
        if (got !== exp) begin
            $display("Mismatch output_pixels[%0d]: got 0x%h, expected 0x%h", index, got, exp);
            abort_run();
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got !== exp) begin
            $display("Mismatch done latency: got 0x%h, expected 0x%h", got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    // Reference pixel of one pool as ones * 2^res / n^2 clipped to the top code
    function automatic pool_pkg::avg_pixel_t model_pixel(input pool_pkg::image_t img,
                                                         input int k);
        int row0;
        int col0;
        int ones;
        int scaled;
        row0 = (k / `POOL_OUT_SIDE) * `POOL_N;
        col0 = (k % `POOL_OUT_SIDE) * `POOL_N;
        ones = 0;
        for (int r = 0; r < `POOL_N; r++) begin
            for (int c = 0; c < `POOL_N; c++) begin
                if (img[(row0 + r) * `POOL_IMG_SIDE + col0 + c]) begin
                    ones++;
                end
            end
        end
        scaled = (ones * (1 << `POOL_OUT_RES)) / `POOL_AREA;
        if (scaled > (1 << `POOL_OUT_RES) - 1) begin
            scaled = (1 << `POOL_OUT_RES) - 1;
        end
        return pool_pkg::avg_pixel_t'(scaled);
    endfunction

    function automatic pool_pkg::image_t make_image(input int kind, input int pool_sel);
        pool_pkg::image_t img;
        int word;
        int row0;
        int col0;
        img = '0;
        word = 0;
        row0 = (pool_sel / `POOL_OUT_SIDE) * `POOL_N;
        col0 = (pool_sel % `POOL_OUT_SIDE) * `POOL_N;
        for (int r = 0; r < `POOL_IMG_SIDE; r++) begin
            for (int c = 0; c < `POOL_IMG_SIDE; c++) begin
                case (kind)
                    KIND_ONES: img[r * `POOL_IMG_SIDE + c] = 1'b1;
                    KIND_CHECKER: img[r * `POOL_IMG_SIDE + c] = ((r + c) % 2 == 1);
                    KIND_POOL: img[r * `POOL_IMG_SIDE + c] = (r >= row0 && r < row0 + `POOL_N
                                                           && c >= col0 && c < col0 + `POOL_N);
                    KIND_RANDOM: begin
                        if ((r * `POOL_IMG_SIDE + c) % 32 == 0) begin
                            word = $random(seed);
                        end
                        img[r * `POOL_IMG_SIDE + c] = word[(r * `POOL_IMG_SIDE + c) % 32];
                    end
                    default: img[r * `POOL_IMG_SIDE + c] = 1'b0;
                endcase
            end
        end
        return img;
    endfunction

    task automatic run_frame(input frame_t f);
        pool_pkg::image_t img;
        int   cyc;
        int   en_edges;
        logic en_prev;
        logic seen;
        img = make_image(f.kind, f.pool_sel);
        // Start cycle with en high so the idle FSM takes it
        @(negedge clk);
        input_pixels = img;
        en = 1'b1;
        start = 1'b1;
        #1;
        check_flag("done", done, 1'b0);
        en_prev = 1'b1;
        en_edges = 0;
        cyc = 0;
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            if (en_prev) begin
                en_edges++;
            end
            cyc++;
            en = (cyc % (f.gap + 1) == 0);
            start = (f.stray_at != 0 && cyc == f.stray_at);
            en_prev = en;
            #1;
            seen = done;
        end
        // Enabled edges counted include the start edge itself
        check_latency(en_edges - 1, `POOL_COUNT + 1);
        for (int k = 0; k < `POOL_COUNT; k++) begin
            check_pixel(k, output_pixels[k*`POOL_OUT_RES +: `POOL_OUT_RES], model_pixel(img, k));
        end
        for (int q = 0; q < f.quiet; q++) begin
            @(negedge clk);
            en = 1'b1;
            start = 1'b0;
            #1;
            check_flag("done", done, 1'b0);
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
        $display("Timeout: the frames did not finish within %0d cycles", WATCHDOG_CYCLES);
        abort_run();
    end

    initial begin
        en = 1'b0;
        start = 1'b0;
        input_pixels = '0;
        seed = 32'h853f;
        frames[0] = '{KIND_ZERO, 0, 0, 4, 0};
        frames[1] = '{KIND_ONES, 0, 0, 4, 0};
        frames[2] = '{KIND_CHECKER, 0, 0, 4, 0};
        frames[3] = '{KIND_POOL, 0, 0, 4, 5};
        // Back to back with the next frame
        frames[4] = '{KIND_RANDOM, 0, 0, 0, 0};
        frames[5] = '{KIND_RANDOM, 2, 0, 4, 0};
        frames[6] = '{KIND_CHECKER, MAX_GAP, 0, 4, 0};
        frames[7] = '{KIND_RANDOM, 0, 6, QUIET_LONG, 0};
        // Extra start lands while the FSM waits in drain
        frames[8] = '{KIND_POOL, 1, 2 * (`POOL_COUNT + 1), QUIET_LONG, 15};

        @(negedge clk);
        while (reset !== 1'b0) begin
            @(negedge clk);
        end
        // Idle after reset with nothing written yet
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            en = 1'b1;
            #1;
            check_flag("done", done, 1'b0);
            for (int k = 0; k < `POOL_COUNT; k++) begin
                check_pixel(k, output_pixels[k*`POOL_OUT_RES +: `POOL_OUT_RES], '0);
            end
        end

        for (int i = 0; i < NUM_FRAMES; i++) begin
            run_frame(frames[i]);
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* average_pooling_top.f */
+incdir+logic
logic/pool_pkg.sv
logic/avg_result_if.sv
logic/pool_sequencer_fsm.sv
logic/pool_counter.sv
logic/pool_gather.sv
logic/pixel_averager.sv
logic/output_buffer.sv
logic/average_pooling_top.sv
tb/clock_gen.sv
tb/average_pooling_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the average pooling testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module average_pooling_tb -f average_pooling_top.f

output=$(./obj_dir/Vaverage_pooling_tb 2>&1) || true
echo "$output"

if echo "$output" | grep -q "Result: PASSED"; then
    exit 0
fi
exit 1
